// File: list.f
source/coms_pkg.sv
source/coms_if.sv
source/uart_tx.sv
source/uart_rx.sv
source/frame_sender.sv
source/status_receiver.sv
source/motor_poller.sv
source/board_coms.sv
tb/motor_model.sv
tb/board_coms_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the board_coms testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module board_coms_tb \
	-f list.f -Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/Vboard_coms_tb > sim.log 2>&1
cat sim.log

grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0

// File: source/board_coms.sv
`timescale 1ns/1ps
`default_nettype none

module board_coms #(
	parameter int NUM_MOTORS = 4,
	parameter int CLK_FREQ_HZ = 1_000_000,
	parameter int BAUD_RATE = 100_000,
	parameter int POLL_CYCLES = 8_000
) (
	input wire clk,
	input wire reset,
	input wire rx,
	output logic tx,
	output logic tx_enable,
	input wire [coms_pkg::ID_WIDTH-1:0] id [NUM_MOTORS],
	input wire signed [coms_pkg::POSITION_WIDTH-1:0] setpoint [NUM_MOTORS],
	output logic signed [coms_pkg::POSITION_WIDTH-1:0] encoder0_position [NUM_MOTORS],
	output logic signed [coms_pkg::CURRENT_WIDTH-1:0] current [NUM_MOTORS],
	output logic [coms_pkg::ERROR_WIDTH-1:0] error_code [NUM_MOTORS]
);

	byte_bus_if byte_bus ();
	frame_cmd_if frame_cmd ();
	status_if status ();

	logic byte_valid;
	logic [coms_pkg::BYTE_WIDTH-1:0] rx_byte;

	////////////////////////////////////////////////////////////
	// transmit path
	motor_poller #(
		.NUM_MOTORS(NUM_MOTORS),
		.CLK_FREQ_HZ(CLK_FREQ_HZ),
		.BAUD_RATE(BAUD_RATE),
		.POLL_CYCLES(POLL_CYCLES)
	) poller_i (
		.clk(clk),
		.reset(reset),
		.id(id),
		.setpoint(setpoint),
		.cmd(frame_cmd),
		.status(status),
		.encoder0_position(encoder0_position),
		.current(current),
		.error_code(error_code)
	);

	frame_sender sender_i (.clk(clk), .reset(reset), .cmd(frame_cmd), .bus(byte_bus));

	uart_tx #(.CLK_FREQ_HZ(CLK_FREQ_HZ), .BAUD_RATE(BAUD_RATE)) uart_tx_i (
		.clk(clk),
		.reset(reset),
		.bus(byte_bus),
		.tx(tx),
		.tx_enable(tx_enable)
	);

	////////////////////////////////////////////////////////////
	// receive path
	uart_rx #(.CLK_FREQ_HZ(CLK_FREQ_HZ), .BAUD_RATE(BAUD_RATE)) uart_rx_i (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.byte_valid(byte_valid),
		.rx_byte(rx_byte)
	);

	status_receiver receiver_i (
		.clk(clk),
		.reset(reset),
		.byte_valid(byte_valid),
		.rx_byte(rx_byte),
		.status(status)
	);

endmodule

`default_nettype wire

// File: source/coms_if.sv
`timescale 1ns/1ps
`default_nettype none

// wishbone classic byte path from frame sender to uart transmitter
interface byte_bus_if;
	logic cyc;
	logic stb;
	logic we;
	logic [coms_pkg::BYTE_WIDTH-1:0] dat;
	logic ack;

	modport master (output cyc, stb, we, dat, input ack);
	modport slave (input cyc, stb, we, dat, output ack);
endinterface

// poller asks the sender for one frame
interface frame_cmd_if;
	logic start;
	logic setpoint_frame;
	logic [coms_pkg::ID_WIDTH-1:0] id;
	logic [coms_pkg::POSITION_WIDTH-1:0] setpoint;
	logic busy;

	modport initiator (output start, setpoint_frame, id, setpoint, input busy);
	modport target (input start, setpoint_frame, id, setpoint, output busy);
endinterface

// decoded status reply, fields hold until the next frame_done
interface status_if;
	logic frame_done;
	logic frame_ok;
	logic [coms_pkg::ID_WIDTH-1:0] id;
	logic [coms_pkg::POSITION_WIDTH-1:0] encoder0;
	logic [coms_pkg::POSITION_WIDTH-1:0] setpoint_actual;
	logic [coms_pkg::CURRENT_WIDTH-1:0] current;

	modport source (output frame_done, frame_ok, id, encoder0, setpoint_actual, current);
	modport sink (input frame_done, frame_ok, id, encoder0, setpoint_actual, current);
endinterface

`default_nettype wire

// File: source/coms_pkg.sv
`default_nettype none

package coms_pkg;

	////////////////////////////////////////////////////////////
	// frame layout
	localparam int MAGIC_LENGTH = 4;
	localparam logic [31:0] STATUS_REQUEST_MAGIC = 32'h1CE1CEBB;
	localparam logic [31:0] STATUS_MAGIC = 32'h1CEB00DA;
	localparam logic [31:0] SETPOINT_MAGIC = 32'hD0D0D0D0;
	localparam int STATUS_REQUEST_LENGTH = 7;
	localparam int STATUS_LENGTH = 28;
	localparam int SETPOINT_LENGTH = 10;
	localparam logic [15:0] CRC_SEED = 16'hFFFF;

	// field widths
	localparam int BYTE_WIDTH = 8;
	localparam int POSITION_WIDTH = 24;
	localparam int CURRENT_WIDTH = 16;
	localparam int ID_WIDTH = 8;
	localparam int ERROR_WIDTH = 2;

	// per motor error codes
	localparam logic [ERROR_WIDTH-1:0] ERR_NONE = 2'd0;
	localparam logic [ERROR_WIDTH-1:0] ERR_PENDING = 2'd1;
	localparam logic [ERROR_WIDTH-1:0] ERR_TIMEOUT = 2'd2;
	localparam logic [ERROR_WIDTH-1:0] ERR_CRC = 2'd3;

	////////////////////////////////////////////////////////////
	// crc-16, x^16+x^15+x^2+1, one byte msb first
	function automatic logic [15:0] crc16_step(input logic [BYTE_WIDTH-1:0] data,
			input logic [15:0] crc);
		logic [15:0] c;
		logic feedback;
		int i;
		c = crc;
		for (i = BYTE_WIDTH - 1; i >= 0; i--) begin
			feedback = c[15] ^ data[i];
			c = {c[14:0], 1'b0};
			if (feedback) begin
				c = c ^ 16'h8005;
			end
		end
		return c;
	endfunction

endpackage

`default_nettype wire

// File: source/frame_sender.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sender (
	input wire clk,
	input wire reset,
	frame_cmd_if.target cmd,
	byte_bus_if.master bus
);

	logic setpoint_frame;
	logic [coms_pkg::ID_WIDTH-1:0] id;
	logic [coms_pkg::POSITION_WIDTH-1:0] setpoint;
	logic [15:0] crc;
	logic [3:0] index;
	logic [3:0] frame_length;
	logic [31:0] magic;
	logic payload;

	assign frame_length = setpoint_frame ? 4'(coms_pkg::SETPOINT_LENGTH) :
		4'(coms_pkg::STATUS_REQUEST_LENGTH);
	assign magic = setpoint_frame ? coms_pkg::SETPOINT_MAGIC : coms_pkg::STATUS_REQUEST_MAGIC;
	// bytes between magic number and crc feed the checksum
	assign payload = index >= 4'(coms_pkg::MAGIC_LENGTH) && index < frame_length - 4'd2;

	////////////////////////////////////////////////////////////
	// byte selection
	always_comb begin
		if (index == frame_length - 4'd2) begin
			bus.dat = crc[15:8];
		end else if (index == frame_length - 4'd1) begin
			bus.dat = crc[7:0];
		end else begin
			case (index)
				4'd0: bus.dat = magic[31:24];
				4'd1: bus.dat = magic[23:16];
				4'd2: bus.dat = magic[15:8];
				4'd3: bus.dat = magic[7:0];
				4'd4: bus.dat = id;
				4'd5: bus.dat = setpoint[23:16];
				4'd6: bus.dat = setpoint[15:8];
				default: bus.dat = setpoint[7:0];
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// bus cycle, held for the whole frame
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cmd.busy <= 1'b0;
			bus.cyc <= 1'b0;
			bus.stb <= 1'b0;
			bus.we <= 1'b0;
			index <= '0;
			setpoint_frame <= 1'b0;
		end else if (!cmd.busy) begin
			if (cmd.start) begin
				cmd.busy <= 1'b1;
				bus.cyc <= 1'b1;
				bus.stb <= 1'b1;
				bus.we <= 1'b1;
				index <= '0;
				setpoint_frame <= cmd.setpoint_frame;
			end
		end else if (bus.ack) begin
			bus.stb <= 1'b0;
			if (!bus.we) begin
				// read acked, last stop bit has left the line
				cmd.busy <= 1'b0;
				bus.cyc <= 1'b0;
			end else begin
				index <= index + 1'b1;
			end
		end else if (!bus.stb) begin
			bus.stb <= 1'b1;
			bus.we <= index != frame_length;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.start && !cmd.busy) begin
			id <= cmd.id;
			setpoint <= cmd.setpoint;
			crc <= coms_pkg::CRC_SEED;
		end else if (bus.ack && bus.we && payload) begin
			crc <= coms_pkg::crc16_step(bus.dat, crc);
		end
	end

	start_when_idle: assert property (@(posedge clk) disable iff (reset)
		cmd.start |-> !cmd.busy);

endmodule

`default_nettype wire

// File: source/motor_poller.sv
`timescale 1ns/1ps
`default_nettype none

module motor_poller #(
	parameter int NUM_MOTORS = 4,
	parameter int CLK_FREQ_HZ = 1_000_000,
	parameter int BAUD_RATE = 100_000,
	parameter int POLL_CYCLES = 8_000
) (
	input wire clk,
	input wire reset,
	input wire [coms_pkg::ID_WIDTH-1:0] id [NUM_MOTORS],
	input wire signed [coms_pkg::POSITION_WIDTH-1:0] setpoint [NUM_MOTORS],
	frame_cmd_if.initiator cmd,
	status_if.sink status,
	output logic signed [coms_pkg::POSITION_WIDTH-1:0] encoder0_position [NUM_MOTORS],
	output logic signed [coms_pkg::CURRENT_WIDTH-1:0] current [NUM_MOTORS],
	output logic [coms_pkg::ERROR_WIDTH-1:0] error_code [NUM_MOTORS]
);

	localparam int BIT_CYCLES = CLK_FREQ_HZ / BAUD_RATE;
	// a full status frame plus one byte of turnaround
	localparam int WINDOW_CYCLES = (coms_pkg::STATUS_LENGTH + 1) * 10 * BIT_CYCLES;
	localparam int POLL_W = $clog2(POLL_CYCLES + 1);
	localparam int WINDOW_W = $clog2(WINDOW_CYCLES + 1);
	localparam int MOTOR_W = (NUM_MOTORS > 1) ? $clog2(NUM_MOTORS) : 1;

	localparam logic [1:0] IDLE = 2'd0;
	localparam logic [1:0] REQUEST = 2'd1;
	localparam logic [1:0] LISTEN = 2'd2;
	localparam logic [1:0] SETPOINT = 2'd3;

	logic [1:0] state;
	logic [MOTOR_W-1:0] motor;
	logic [POLL_W-1:0] poll_timer;
	logic [WINDOW_W-1:0] window_timer;
	logic busy_q;
	logic busy_fall;
	logic reply_good;

	function automatic logic [MOTOR_W-1:0] next_motor(input logic [MOTOR_W-1:0] m);
		return (m == MOTOR_W'(NUM_MOTORS - 1)) ? '0 : m + 1'b1;
	endfunction

	assign busy_fall = busy_q && !cmd.busy;
	assign reply_good = status.frame_ok && status.id == id[motor];
	assign cmd.id = id[motor];
	assign cmd.setpoint = setpoint[motor];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			motor <= '0;
			poll_timer <= '0;
			window_timer <= '0;
			busy_q <= 1'b0;
			cmd.start <= 1'b0;
			cmd.setpoint_frame <= 1'b0;
			for (int m = 0; m < NUM_MOTORS; m++) begin
				encoder0_position[m] <= '0;
				current[m] <= '0;
				error_code[m] <= coms_pkg::ERR_PENDING;
			end
		end else begin
			busy_q <= cmd.busy;
			cmd.start <= 1'b0;
			if (poll_timer != '0) begin
				poll_timer <= poll_timer - 1'b1;
			end
			case (state)
				IDLE: begin
					if (poll_timer == '0 && !cmd.busy) begin
						cmd.start <= 1'b1;
						cmd.setpoint_frame <= 1'b0;
						poll_timer <= POLL_W'(POLL_CYCLES - 1);
						state <= REQUEST;
					end
				end
				REQUEST: begin
					// response window opens once the request is off the line
					if (busy_fall) begin
						window_timer <= WINDOW_W'(WINDOW_CYCLES - 1);
						state <= LISTEN;
					end
				end
				LISTEN: begin
					if (status.frame_done && reply_good) begin
						encoder0_position[motor] <= status.encoder0;
						current[motor] <= status.current;
						error_code[motor] <= coms_pkg::ERR_NONE;
						if (status.setpoint_actual != setpoint[motor]) begin
							cmd.start <= 1'b1;
							cmd.setpoint_frame <= 1'b1;
							state <= SETPOINT;
						end else begin
							motor <= next_motor(motor);
							state <= IDLE;
						end
					end else if (status.frame_done) begin
						error_code[motor] <= coms_pkg::ERR_CRC;
						motor <= next_motor(motor);
						state <= IDLE;
					end else if (window_timer == '0) begin
						error_code[motor] <= coms_pkg::ERR_TIMEOUT;
						motor <= next_motor(motor);
						state <= IDLE;
					end else begin
						window_timer <= window_timer - 1'b1;
					end
				end
				default: begin
					if (busy_fall) begin
						motor <= next_motor(motor);
						state <= IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/status_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module status_receiver (
	input wire clk,
	input wire reset,
	input wire byte_valid,
	input wire [coms_pkg::BYTE_WIDTH-1:0] rx_byte,
	status_if.source status
);

	// everything after the magic number, crc included
	localparam int BODY_LENGTH = coms_pkg::STATUS_LENGTH - coms_pkg::MAGIC_LENGTH;
	localparam int CRC_OFFSET = BODY_LENGTH - 2;

	logic [31:0] magic_window;
	logic magic_seen;
	logic collecting;
	logic [4:0] count;
	logic last_byte;
	logic [15:0] crc;
	logic [coms_pkg::BYTE_WIDTH-1:0] body [BODY_LENGTH];

	assign magic_seen = {magic_window[23:0], rx_byte} == coms_pkg::STATUS_MAGIC;
	assign last_byte = collecting && count == 5'(BODY_LENGTH - 1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			magic_window <= '0;
			collecting <= 1'b0;
			count <= '0;
			status.frame_done <= 1'b0;
			status.frame_ok <= 1'b0;
		end else begin
			status.frame_done <= 1'b0;
			if (byte_valid) begin
				magic_window <= {magic_window[23:0], rx_byte};
				// a fresh magic number restarts collection
				if (magic_seen) begin
					collecting <= 1'b1;
					count <= '0;
				end else if (collecting) begin
					count <= count + 1'b1;
					if (last_byte) begin
						collecting <= 1'b0;
						status.frame_done <= 1'b1;
						status.frame_ok <= crc == {body[CRC_OFFSET], rx_byte};
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// payload, crc and field decode
	always_ff @(posedge clk) begin
		if (byte_valid) begin
			if (magic_seen) begin
				crc <= coms_pkg::CRC_SEED;
			end else if (collecting) begin
				body[count] <= rx_byte;
				if (count < 5'(CRC_OFFSET)) begin
					crc <= coms_pkg::crc16_step(rx_byte, crc);
				end
				// big endian fields at offsets 0, 2, 8 and 17
				if (last_byte) begin
					status.id <= body[0];
					status.encoder0 <= {body[2], body[3], body[4]};
					status.setpoint_actual <= {body[8], body[9], body[10]};
					status.current <= {body[17], body[18]};
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int CLK_FREQ_HZ = 1_000_000,
	parameter int BAUD_RATE = 100_000
) (
	input wire clk,
	input wire reset,
	input wire rx,
	output logic byte_valid,
	output logic [coms_pkg::BYTE_WIDTH-1:0] rx_byte
);

	localparam int BIT_CYCLES = CLK_FREQ_HZ / BAUD_RATE;
	localparam int CNT_W = $clog2(BIT_CYCLES + 1);

	logic [1:0] rx_sync;
	logic active;
	logic [3:0] bit_index;
	logic [CNT_W-1:0] cycle_count;
	logic data_sample;

	// bits 1..8 are data, 0 is start and 9 is stop
	assign data_sample = active && cycle_count == '0 && bit_index != 4'd0 && bit_index != 4'd9;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_sync <= 2'b11;
			active <= 1'b0;
			bit_index <= '0;
			cycle_count <= '0;
			byte_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			byte_valid <= 1'b0;
			if (!active) begin
				if (!rx_sync[1]) begin
					// falling edge of a start bit, wait for its middle
					active <= 1'b1;
					bit_index <= '0;
					cycle_count <= CNT_W'(BIT_CYCLES / 2 - 1);
				end
			end else if (cycle_count != '0) begin
				cycle_count <= cycle_count - 1'b1;
			end else begin
				cycle_count <= CNT_W'(BIT_CYCLES - 1);
				bit_index <= bit_index + 1'b1;
				if (bit_index == 4'd0) begin
					// start bit gone high again, was only a glitch
					active <= !rx_sync[1];
				end else if (bit_index == 4'd9) begin
					active <= 1'b0;
					byte_valid <= rx_sync[1];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (data_sample) begin
			rx_byte <= {rx_sync[1], rx_byte[coms_pkg::BYTE_WIDTH-1:1]};
		end
	end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter int CLK_FREQ_HZ = 1_000_000,
	parameter int BAUD_RATE = 100_000
) (
	input wire clk,
	input wire reset,
	byte_bus_if.slave bus,
	output logic tx,
	output logic tx_enable
);

	localparam int BIT_CYCLES = CLK_FREQ_HZ / BAUD_RATE;
	localparam int CNT_W = $clog2(BIT_CYCLES + 1);

	logic [9:0] shifter;
	logic [3:0] bit_count;
	logic [CNT_W-1:0] cycle_count;
	logic accept;

	// only an idle line answers; a read strobe just reports that it is free
	assign accept = bus.cyc && bus.stb && !bus.ack && !tx_enable;
	assign tx = shifter[0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			shifter <= '1;
			bit_count <= '0;
			cycle_count <= '0;
			tx_enable <= 1'b0;
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= accept;
			if (accept && bus.we) begin
				// stop bit, data lsb first, start bit
				shifter <= {1'b1, bus.dat, 1'b0};
				bit_count <= '0;
				cycle_count <= CNT_W'(BIT_CYCLES - 1);
				tx_enable <= 1'b1;
			end else if (tx_enable) begin
				if (cycle_count != '0) begin
					cycle_count <= cycle_count - 1'b1;
				end else if (bit_count == 4'd9) begin
					tx_enable <= 1'b0;
				end else begin
					shifter <= {1'b1, shifter[9:1]};
					bit_count <= bit_count + 1'b1;
					cycle_count <= CNT_W'(BIT_CYCLES - 1);
				end
			end
		end
	end

	// the sender has to keep strobing until it sees the ack
	ack_with_stb: assert property (@(posedge clk) disable iff (reset)
		$rose(bus.ack) |-> bus.stb);

endmodule

`default_nettype wire

// File: tb/board_coms_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_coms_tb;

	localparam int NUM_MOTORS = 4;
	localparam int CLK_FREQ_HZ = 1_000_000;
	localparam int BAUD_RATE = 100_000;
	localparam int POLL_CYCLES = 8_000;
	localparam int BIT_CYCLES = CLK_FREQ_HZ / BAUD_RATE;
	localparam int CLK_PERIOD = 10;
	localparam int ROWS = 12;
	localparam int WATCHDOG_NS = ROWS * 2 * POLL_CYCLES * CLK_PERIOD;

	localparam int MODE_GOOD = 0;
	localparam int MODE_BAD_CRC = 1;
	localparam int MODE_WRONG_ID = 2;
	localparam int MODE_SILENT = 3;

	logic clk;
	logic reset;
	logic rx;
	logic tx;
	logic tx_enable;
	logic [coms_pkg::ID_WIDTH-1:0] id [NUM_MOTORS];
	logic signed [coms_pkg::POSITION_WIDTH-1:0] setpoint [NUM_MOTORS];
	logic signed [coms_pkg::POSITION_WIDTH-1:0] encoder0_position [NUM_MOTORS];
	logic signed [coms_pkg::CURRENT_WIDTH-1:0] current [NUM_MOTORS];
	logic [coms_pkg::ERROR_WIDTH-1:0] error_code [NUM_MOTORS];
	logic [1:0] reply_mode;
	logic [23:0] reply_encoder;
	logic [15:0] reply_current;
	logic [23:0] reply_actual;

	// motors are taken in turn, row r polls motor r mod 4
	int script_mode [ROWS] = '{0, 0, 1, 0, 2, 3, 0, 3, 0, 1, 0, 2};
	bit script_differ [ROWS] = '{1, 0, 0, 1, 0, 0, 0, 0, 1, 0, 1, 0};

	////////////////////////////////////////////////////////////
	// stimulus and expected values
	int row_motor [ROWS];
	int row_mode [ROWS];
	logic [23:0] row_encoder [ROWS];
	logic [15:0] row_current [ROWS];
	logic [23:0] row_setpoint [ROWS];
	logic [23:0] row_actual [ROWS];
	logic [1:0] row_error [ROWS];
	bit row_setpoint_frame [ROWS];

	logic [23:0] exp_encoder [NUM_MOTORS];
	logic [15:0] exp_current [NUM_MOTORS];
	logic [1:0] exp_error [NUM_MOTORS];

	int seed = 32'h52c2_f9a5;
	int checks = 0;
	int errors = 0;
	int row_errors;

	board_coms #(
		.NUM_MOTORS(NUM_MOTORS),
		.CLK_FREQ_HZ(CLK_FREQ_HZ),
		.BAUD_RATE(BAUD_RATE),
		.POLL_CYCLES(POLL_CYCLES)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.tx(tx),
		.tx_enable(tx_enable),
		.id(id),
		.setpoint(setpoint),
		.encoder0_position(encoder0_position),
		.current(current),
		.error_code(error_code)
	);

	motor_model #(.BIT_CYCLES(BIT_CYCLES)) model_i (
		.clk(clk),
		.tx(tx),
		.tx_enable(tx_enable),
		.rx(rx),
		.reply_mode(reply_mode),
		.reply_encoder(reply_encoder),
		.reply_current(reply_current),
		.reply_actual(reply_actual)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic string mode_name(input int mode);
		case (mode)
			MODE_GOOD: return "good";
			MODE_BAD_CRC: return "bad crc";
			MODE_WRONG_ID: return "wrong id";
			default: return "silent";
		endcase
	endfunction

	task automatic fill_table();
		int r;
		for (r = 0; r < ROWS; r++) begin
			row_motor[r] = r % NUM_MOTORS;
			row_mode[r] = script_mode[r];
			row_encoder[r] = 24'($random(seed));
			row_current[r] = 16'($random(seed));
			row_setpoint[r] = 24'($random(seed));
			row_actual[r] = 24'($random(seed));
			row_setpoint_frame[r] = row_mode[r] == MODE_GOOD && script_differ[r];
			if (row_mode[r] == MODE_GOOD && !script_differ[r]) begin
				row_actual[r] = row_setpoint[r];
			end else if (row_actual[r] == row_setpoint[r]) begin
				row_actual[r] = row_setpoint[r] ^ 24'h1;
			end
			case (row_mode[r])
				MODE_GOOD: row_error[r] = coms_pkg::ERR_NONE;
				MODE_SILENT: row_error[r] = coms_pkg::ERR_TIMEOUT;
				default: row_error[r] = coms_pkg::ERR_CRC;
			endcase
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
			errors++;
			row_errors++;
		end
	endtask

	// request of row r first, then any setpoint frames
	task automatic check_frames(input int r);
		logic [31:0] magic;
		logic [7:0] fid;
		logic [23:0] fsp;
		logic fok;
		int sp_frames;
		int m;
		m = row_motor[r];
		sp_frames = 0;
		model_i.take_frame(magic, fid, fsp, fok);
		check_value("request magic", magic, coms_pkg::STATUS_REQUEST_MAGIC);
		check_value("request id", fid, id[m]);
		check_value("request crc_ok", fok, 1);
		while (model_i.frame_count() > 0) begin
			model_i.take_frame(magic, fid, fsp, fok);
			sp_frames++;
			check_value("setpoint frame magic", magic, coms_pkg::SETPOINT_MAGIC);
			check_value("setpoint frame id", fid, id[m]);
			check_value("setpoint frame setpoint", fsp, row_setpoint[r]);
			check_value("setpoint frame crc_ok", fok, 1);
		end
		check_value("setpoint frame count", sp_frames, row_setpoint_frame[r]);
	endtask

	task automatic check_outputs();
		int m;
		for (m = 0; m < NUM_MOTORS; m++) begin
			check_value($sformatf("encoder0_position[%0d]", m), {8'h00, encoder0_position[m]},
				exp_encoder[m]);
			check_value($sformatf("current[%0d]", m), {16'h0000, current[m]}, exp_current[m]);
			check_value($sformatf("error_code[%0d]", m), error_code[m], exp_error[m]);
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	initial begin : main
		int r;
		int m;
		reset = 1'b1;
		reply_mode = '0;
		reply_encoder = '0;
		reply_current = '0;
		reply_actual = '0;
		for (m = 0; m < NUM_MOTORS; m++) begin
			id[m] = '0;
			setpoint[m] = '0;
			exp_encoder[m] = '0;
			exp_current[m] = '0;
			exp_error[m] = coms_pkg::ERR_PENDING;
		end
		fill_table();
		@(posedge clk);
		for (m = 0; m < NUM_MOTORS; m++) begin
			id[m] <= 8'h40 + 8'(m);
		end
		@(posedge clk);
		reset <= 1'b0;

		for (r = 0; r < ROWS; r++) begin
			m = row_motor[r];
			row_errors = 0;
			// request r is under way, its reply comes from these
			@(posedge clk);
			setpoint[m] <= row_setpoint[r];
			reply_mode <= 2'(row_mode[r]);
			reply_encoder <= row_encoder[r];
			reply_current <= row_current[r];
			reply_actual <= row_actual[r];
			while (model_i.requests_seen < r + 2) @(posedge clk);
			@(negedge clk);
			check_frames(r);
			if (row_mode[r] == MODE_GOOD) begin
				exp_encoder[m] = row_encoder[r];
				exp_current[m] = row_current[r];
			end
			exp_error[m] = row_error[r];
			check_outputs();
			$display("row %0d motor %0d %s: %s", r, m, mode_name(row_mode[r]),
				row_errors == 0 ? "ok" : "failed");
		end

		checks++;
		assert (model_i.enable_errors == 0) else begin
			$display("tx_enable was wrong during %0d sampled bits", model_i.enable_errors);
			errors++;
		end
		$display("%0d rows, %0d checks, %0d errors", ROWS, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, polling stalled", WATCHDOG_NS);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/motor_model.sv
`timescale 1ns/1ps
`default_nettype none

module motor_model #(
	parameter int BIT_CYCLES = 10
) (
	input wire clk,
	input wire tx,
	input wire tx_enable,
	output logic rx,
	input wire [1:0] reply_mode,
	input wire [23:0] reply_encoder,
	input wire [15:0] reply_current,
	input wire [23:0] reply_actual
);

	localparam logic [1:0] MODE_BAD_CRC = 2'd1;
	localparam logic [1:0] MODE_WRONG_ID = 2'd2;
	localparam logic [1:0] MODE_SILENT = 2'd3;

	// one entry per decoded frame
	logic [31:0] magic_q [$];
	logic [7:0] id_q [$];
	logic [23:0] setpoint_q [$];
	logic crc_ok_q [$];

	int requests_seen = 0;
	int enable_errors = 0;
	logic [7:0] request_id;
	event reply_request;

	initial rx = 1'b1;

	function automatic int frame_count();
		return magic_q.size();
	endfunction

	task automatic take_frame(output logic [31:0] magic, output logic [7:0] id,
			output logic [23:0] setpoint, output logic crc_ok);
		magic = magic_q.pop_front();
		id = id_q.pop_front();
		setpoint = setpoint_q.pop_front();
		crc_ok = crc_ok_q.pop_front();
	endtask

	// called on the falling edge of a start bit
	task automatic receive_byte(output logic [7:0] b);
		int i;
		repeat (BIT_CYCLES / 2) @(posedge clk);
		for (i = 0; i < 8; i++) begin
			repeat (BIT_CYCLES) @(posedge clk);
			b[i] = tx;
			if (!tx_enable) enable_errors++;
		end
		// middle of the stop bit
		repeat (BIT_CYCLES) @(posedge clk);
		if (!tx_enable) enable_errors++;
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		int i;
		bits = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			rx <= bits[i];
			if (tx_enable) enable_errors++;
			repeat (BIT_CYCLES - 1) @(posedge clk);
		end
	endtask

	////////////////////////////////////////////////////////////
	// frame decode on tx
	initial begin : decode
		logic [7:0] frame [10];
		logic [7:0] b;
		logic [31:0] magic;
		logic [15:0] crc;
		int n;
		int len;
		int i;
		n = 0;
		len = 0;
		forever begin
			@(negedge tx);
			receive_byte(b);
			frame[n] = b;
			n++;
			if (n == 4) begin
				magic = {frame[0], frame[1], frame[2], frame[3]};
				if (magic == coms_pkg::STATUS_REQUEST_MAGIC) begin
					len = coms_pkg::STATUS_REQUEST_LENGTH;
					requests_seen++;
				end else if (magic == coms_pkg::SETPOINT_MAGIC) begin
					len = coms_pkg::SETPOINT_LENGTH;
				end else begin
					// unknown magic, logged and dropped
					magic_q.push_back(magic);
					id_q.push_back('0);
					setpoint_q.push_back('0);
					crc_ok_q.push_back(1'b0);
					n = 0;
				end
			end
			if (n >= 4 && n == len) begin
				crc = coms_pkg::CRC_SEED;
				for (i = 4; i < len - 2; i++) begin
					crc = coms_pkg::crc16_step(frame[i], crc);
				end
				magic_q.push_back(magic);
				id_q.push_back(frame[4]);
				setpoint_q.push_back(len == 10 ? {frame[5], frame[6], frame[7]} : 24'h0);
				crc_ok_q.push_back(crc == {frame[len-2], frame[len-1]});
				n = 0;
				if (len == coms_pkg::STATUS_REQUEST_LENGTH) begin
					request_id = frame[4];
					->reply_request;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// status reply on rx
	initial begin : reply
		logic [7:0] bytes [28];
		logic [15:0] crc;
		int i;
		forever begin
			@(reply_request);
			wait (!tx_enable);
			// one bit time of line turnaround
			repeat (BIT_CYCLES) @(posedge clk);
			if (reply_mode != MODE_SILENT) begin
				for (i = 0; i < 28; i++) begin
					bytes[i] = 8'(i * 23);
				end
				{bytes[0], bytes[1], bytes[2], bytes[3]} = coms_pkg::STATUS_MAGIC;
				bytes[4] = (reply_mode == MODE_WRONG_ID) ? request_id ^ 8'h80 : request_id;
				{bytes[6], bytes[7], bytes[8]} = reply_encoder;
				{bytes[12], bytes[13], bytes[14]} = reply_actual;
				{bytes[21], bytes[22]} = reply_current;
				crc = coms_pkg::CRC_SEED;
				for (i = 4; i < 26; i++) begin
					crc = coms_pkg::crc16_step(bytes[i], crc);
				end
				if (reply_mode == MODE_BAD_CRC) crc = crc ^ 16'h0101;
				bytes[26] = crc[15:8];
				bytes[27] = crc[7:0];
				for (i = 0; i < 28; i++) begin
					send_byte(bytes[i]);
				end
			end
		end
	end

endmodule

`default_nettype wire
